// ==== core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath
`define DATA_W 32

// register file
`define NREGS 16
`define REG_IDX_W 4

// instruction fields
`define OP_W 4
`define COND_W 4
`define IMM_W 12

// low bits of operand b used as shift count
`define SHAMT_W 5

`endif

// ==== isa_pkg.sv ====
`include "core_consts.svh"

package isa_pkg;

  typedef enum logic [`OP_W-1:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_ADDI = 4'd3,
    OP_AND  = 4'd4,
    OP_OR   = 4'd5,
    OP_XOR  = 4'd6,
    OP_SHL  = 4'd7,
    OP_SHR  = 4'd8,
    OP_SAR  = 4'd9,
    OP_SHLI = 4'd10,
    OP_SHRI = 4'd11,
    OP_SARI = 4'd12,
    OP_SXT  = 4'd13, // mode in imm[1:0]
    OP_MOVI = 4'd14,
    OP_CMP  = 4'd15  // sub without rd write
  } opcode_e;

  typedef enum logic [`COND_W-1:0] {
    CC_EQ = 4'd0,
    CC_NE = 4'd1,
    CC_CS = 4'd2,
    CC_CC = 4'd3,
    CC_MI = 4'd4,
    CC_PL = 4'd5,
    CC_VS = 4'd6,
    CC_VC = 4'd7,
    CC_HI = 4'd8,  // unsigned higher
    CC_LS = 4'd9,
    CC_GE = 4'd10, // signed
    CC_LT = 4'd11,
    CC_GT = 4'd12,
    CC_LE = 4'd13,
    CC_AL = 4'd14,
    CC_NV = 4'd15
  } cond_e;

  // op occupies the top nibble
  typedef struct packed {
    opcode_e               op;
    cond_e                 cond;
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] ra;
    logic [`REG_IDX_W-1:0] rb;
    logic [`IMM_W-1:0]     imm;
  } insn_t;

endpackage

// ==== core_pkg.sv ====
`include "core_consts.svh"

package core_pkg;

  import isa_pkg::*;

  typedef struct packed {
    logic z;
    logic s;
    logic c; // no borrow on sub
    logic v;
  } flags_t;

  typedef struct packed {
    logic                  valid;
    opcode_e               op;
    cond_e                 cond;
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] ra;
    logic [`REG_IDX_W-1:0] rb;
    logic [`DATA_W-1:0]    imm;        // sign-extended
    logic                  use_imm;    // operand b from imm
    logic                  writes_reg;
    logic                  sets_flags;
  } dec_t;

  typedef struct packed {
    logic                  valid;
    logic                  executed; // cond held, not a nop
    logic                  write_en;
    logic [`REG_IDX_W-1:0] rd;
    logic [`DATA_W-1:0]    data;
    flags_t                flags;    // value after this insn
  } exe_t;

  typedef struct packed {
    logic [`REG_IDX_W-1:0] rd;
    logic [`DATA_W-1:0]    data;
    logic                  written;
    flags_t                flags;
  } res_t;

endpackage

// ==== insn_decode.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module insn_decode
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  instr_valid,
  input  insn_t instr,
  output dec_t  dec_q
);

  logic [`DATA_W-1:0] imm_sx;
  logic               use_imm;
  logic               writes_reg;
  logic               sets_flags;

  assign imm_sx = {{(`DATA_W-`IMM_W){instr.imm[`IMM_W-1]}}, instr.imm};

  always_comb begin
    use_imm    = 1'b0;
    writes_reg = 1'b1;
    sets_flags = 1'b1;
    case (instr.op)
      OP_ADDI, OP_SHLI, OP_SHRI, OP_SARI, OP_SXT, OP_MOVI: use_imm = 1'b1;
      OP_NOP: begin
        writes_reg = 1'b0;
        sets_flags = 1'b0;
      end
      OP_CMP: writes_reg = 1'b0; // flags only
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_q.valid <= 1'b0;
    end else begin
      dec_q.valid <= instr_valid;
    end
    dec_q.op         <= instr.op;
    dec_q.cond       <= instr.cond;
    dec_q.rd         <= instr.rd;
    dec_q.ra         <= instr.ra;
    dec_q.rb         <= instr.rb;
    dec_q.imm        <= imm_sx;
    dec_q.use_imm    <= use_imm;
    dec_q.writes_reg <= writes_reg;
    dec_q.sets_flags <= sets_flags;
  end

  // a sampled word must be fully driven
  a_instr_known: assert property (
    @(posedge clk) disable iff (rst)
    instr_valid |-> !$isunknown(instr)
  );

endmodule

// ==== alu_execute.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module alu_execute
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  dec_t               dec_q,
  input  logic [`DATA_W-1:0] rd_a_data,
  input  logic [`DATA_W-1:0] rd_b_data,
  input  flags_t             cur_flags,
  output exe_t               exe_q
);

  logic [`DATA_W-1:0]  op_a;
  logic [`DATA_W-1:0]  op_b;
  logic [`SHAMT_W-1:0] shamt;
  logic [`DATA_W:0]    add_w;
  logic [`DATA_W:0]    sub_w;
  logic [`DATA_W-1:0]  alu_res;
  logic                carry;
  logic                ovf;
  logic                cond_ok;
  logic                executed;
  flags_t              new_flags;

  function automatic logic cond_hold(input cond_e cc, input flags_t f);
    logic ge;
    logic hi;
    ge = (f.s == f.v);
    hi = f.c & ~f.z;
    case (cc)
      CC_EQ: cond_hold = f.z;
      CC_NE: cond_hold = ~f.z;
      CC_CS: cond_hold = f.c;
      CC_CC: cond_hold = ~f.c;
      CC_MI: cond_hold = f.s;
      CC_PL: cond_hold = ~f.s;
      CC_VS: cond_hold = f.v;
      CC_VC: cond_hold = ~f.v;
      CC_HI: cond_hold = hi;
      CC_LS: cond_hold = ~hi;
      CC_GE: cond_hold = ge;
      CC_LT: cond_hold = ~ge;
      CC_GT: cond_hold = ~f.z & ge;
      CC_LE: cond_hold = ~(~f.z & ge);
      CC_AL: cond_hold = 1'b1;
      default: cond_hold = 1'b0; // nv
    endcase
  endfunction

  assign op_a  = rd_a_data;
  assign op_b  = dec_q.use_imm ? dec_q.imm : rd_b_data;
  assign shamt = op_b[`SHAMT_W-1:0];
  assign add_w = {1'b0, op_a} + {1'b0, op_b};
  assign sub_w = {1'b0, op_a} + {1'b0, ~op_b} + {{`DATA_W{1'b0}}, 1'b1}; // carry out = no borrow

  always_comb begin
    alu_res = '0;
    carry   = cur_flags.c; // c and v only move on arithmetic
    ovf     = cur_flags.v;
    case (dec_q.op)
      OP_ADD, OP_ADDI: begin
        alu_res = add_w[`DATA_W-1:0];
        carry   = add_w[`DATA_W];
        ovf     = (op_a[`DATA_W-1] == op_b[`DATA_W-1]) &&
                  (add_w[`DATA_W-1] != op_a[`DATA_W-1]);
      end
      OP_SUB, OP_CMP: begin
        alu_res = sub_w[`DATA_W-1:0];
        carry   = sub_w[`DATA_W];
        ovf     = (op_a[`DATA_W-1] != op_b[`DATA_W-1]) &&
                  (sub_w[`DATA_W-1] != op_a[`DATA_W-1]);
      end
      OP_AND: alu_res = op_a & op_b;
      OP_OR:  alu_res = op_a | op_b;
      OP_XOR: alu_res = op_a ^ op_b;
      OP_SHL, OP_SHLI: alu_res = op_a << shamt;
      OP_SHR, OP_SHRI: alu_res = op_a >> shamt;
      OP_SAR, OP_SARI: alu_res = $signed(op_a) >>> shamt;
      OP_SXT: begin
        case (dec_q.imm[1:0])
          2'd0: alu_res = {{(`DATA_W-8){op_a[7]}}, op_a[7:0]};
          2'd1: alu_res = {{(`DATA_W-16){op_a[15]}}, op_a[15:0]};
          2'd2: alu_res = {{(`DATA_W-8){1'b0}}, op_a[7:0]};
          default: alu_res = {op_a[7:0], op_a[15:8], op_a[23:16], op_a[31:24]};
        endcase
      end
      OP_MOVI: alu_res = op_b;
      default: ; // nop
    endcase
  end

  assign cond_ok  = cond_hold(dec_q.cond, cur_flags);
  assign executed = dec_q.valid && cond_ok && (dec_q.op != OP_NOP);

  always_comb begin
    new_flags = cur_flags;
    if (executed && dec_q.sets_flags) begin
      new_flags.z = (alu_res == '0);
      new_flags.s = alu_res[`DATA_W-1];
      new_flags.c = carry;
      new_flags.v = ovf;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_q.valid    <= 1'b0;
      exe_q.executed <= 1'b0;
      exe_q.write_en <= 1'b0;
    end else begin
      exe_q.valid    <= dec_q.valid;
      exe_q.executed <= executed;
      exe_q.write_en <= executed && dec_q.writes_reg;
    end
    exe_q.rd    <= dec_q.rd;
    exe_q.data  <= alu_res; // raw result even when not written
    exe_q.flags <= new_flags;
  end

  a_no_write_cmp_nop: assert property (
    @(posedge clk) disable iff (rst)
    dec_q.valid && (dec_q.op inside {OP_CMP, OP_NOP}) |=> !exe_q.write_en
  );

endmodule

// ==== result_commit.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module result_commit
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  exe_t                  exe_q,
  input  logic [`REG_IDX_W-1:0] rd_a_idx,
  input  logic [`REG_IDX_W-1:0] rd_b_idx,
  output logic [`DATA_W-1:0]    rd_a_data,
  output logic [`DATA_W-1:0]    rd_b_data,
  output flags_t                cur_flags,
  output logic                  result_valid,
  output res_t                  result
);

  logic [`DATA_W-1:0] regs [`NREGS];
  flags_t             flags_q;
  logic               reg_wr;
  logic               flag_wr;

  assign reg_wr  = exe_q.valid && exe_q.write_en;
  assign flag_wr = exe_q.valid && exe_q.executed;

  // read port with write-through of the pending exe_q result
  function automatic logic [`DATA_W-1:0] bypass_rd(input logic [`REG_IDX_W-1:0] idx);
    if (reg_wr && (exe_q.rd == idx)) begin
      bypass_rd = exe_q.data;
    end else begin
      bypass_rd = regs[idx];
    end
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0; // regs read zero after reset
      end
      flags_q <= '0;
    end else begin
      if (reg_wr) regs[exe_q.rd] <= exe_q.data;
      if (flag_wr) flags_q <= exe_q.flags;
    end
  end

  always_comb begin
    rd_a_data = bypass_rd(rd_a_idx);
    rd_b_data = bypass_rd(rd_b_idx);
  end

  assign cur_flags = flag_wr ? exe_q.flags : flags_q;

  assign result_valid   = exe_q.valid;
  assign result.rd      = exe_q.rd;
  assign result.data    = exe_q.data;
  assign result.written = exe_q.write_en;
  assign result.flags   = exe_q.flags;

  // pipeline drains through reset in one edge
  a_quiet_after_rst: assert property (
    @(posedge clk) rst |=> !result_valid
  );

endmodule

// ==== alu_core.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module alu_core
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  instr_valid,
  input  insn_t instr,
  output logic  result_valid,
  output res_t  result
);

  dec_t               dec_q;
  exe_t               exe_q;
  logic [`DATA_W-1:0] rd_a_data;
  logic [`DATA_W-1:0] rd_b_data;
  flags_t             cur_flags;

  insn_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec_q       (dec_q)
  );

  alu_execute u_execute (
    .clk       (clk),
    .rst       (rst),
    .dec_q     (dec_q),
    .rd_a_data (rd_a_data),
    .rd_b_data (rd_b_data),
    .cur_flags (cur_flags),
    .exe_q     (exe_q)
  );

  result_commit u_commit (
    .clk          (clk),
    .rst          (rst),
    .exe_q        (exe_q),
    .rd_a_idx     (dec_q.ra), // operands read during execute
    .rd_b_idx     (dec_q.rb),
    .rd_a_data    (rd_a_data),
    .rd_b_data    (rd_b_data),
    .cur_flags    (cur_flags),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// ==== tb_alu_core.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_alu_core
  import isa_pkg::*;
  import core_pkg::*;
();

  localparam int NUM_INSNS   = 2000;
  localparam int CLK_PERIOD  = 8;
  localparam int WATCHDOG_NS = (NUM_INSNS + 20) * CLK_PERIOD * 2;

  logic   clk;
  logic   rst;
  logic   instr_valid;
  insn_t  instr;
  logic   result_valid;
  res_t   result;

  integer seed;
  int     cyc = 0;
  int     issued = 0;
  logic [31:0] roll;

  // reference state
  logic [`DATA_W-1:0] m_regs [`NREGS];
  flags_t             m_flags;
  res_t               exp_q[$];
  int                 due_q[$]; // cycle in which each result must show

  alu_core u_dut (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc = cyc + 1;

  task automatic report_mismatch(input string what);
    $display("Fail at %0t ns: %s", $time, what);
    $display("Verification failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_result(input res_t got, input res_t exp);
    string got_s;
    if (got.rd !== exp.rd || got.data !== exp.data || got.written !== exp.written) begin
      got_s = $sformatf("result rd %0d data %h written %b", got.rd, got.data, got.written);
      report_mismatch($sformatf("%s, expected rd %0d data %h written %b", got_s,
                                exp.rd, exp.data, exp.written));
    end
  endtask

  task automatic check_flags(input flags_t got, input flags_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("flags zscv %b, expected %b", got, exp));
    end
  endtask

  // odd codes are the negation of the even code below them
  function automatic logic cond_true(input logic [3:0] cc, input flags_t f);
    logic base;
    case (cc[3:1])
      3'd0: base = f.z;
      3'd1: base = f.c;
      3'd2: base = f.s;
      3'd3: base = f.v;
      3'd4: base = f.c && !f.z;
      3'd5: base = (f.s == f.v);
      3'd6: base = !f.z && (f.s == f.v);
      default: base = 1'b1; // al / nv
    endcase
    return cc[0] ? !base : base;
  endfunction

  task automatic model_issue(input insn_t i);
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] imm;
    logic [`DATA_W-1:0] r;
    logic [`DATA_W:0]   wide;
    longint             sres;
    logic               c;
    logic               v;
    logic               run;
    res_t               e;
    imm = {{(`DATA_W-`IMM_W){i.imm[`IMM_W-1]}}, i.imm};
    a = m_regs[i.ra];
    if (i.op inside {OP_ADDI, OP_SHLI, OP_SHRI, OP_SARI, OP_SXT, OP_MOVI}) b = imm;
    else b = m_regs[i.rb];
    c = m_flags.c;
    v = m_flags.v;
    r = '0;
    case (i.op)
      OP_ADD, OP_ADDI: begin
        wide = {1'b0, a} + {1'b0, b};
        r    = wide[`DATA_W-1:0];
        c    = wide[`DATA_W];
        sres = $signed(a) + $signed(b);
        v    = (sres != $signed(r)); // true sum does not fit
      end
      OP_SUB, OP_CMP: begin
        r    = a - b;
        c    = (a >= b); // no borrow
        sres = $signed(a) - $signed(b);
        v    = (sres != $signed(r));
      end
      OP_AND: r = a & b;
      OP_OR:  r = a | b;
      OP_XOR: r = a ^ b;
      OP_SHL, OP_SHLI: r = a << b[`SHAMT_W-1:0];
      OP_SHR, OP_SHRI: r = a >> b[`SHAMT_W-1:0];
      OP_SAR, OP_SARI: r = $signed(a) >>> b[`SHAMT_W-1:0];
      OP_SXT: begin
        case (i.imm[1:0])
          2'd0: r = {{24{a[7]}}, a[7:0]};
          2'd1: r = {{16{a[15]}}, a[15:0]};
          2'd2: r = {24'd0, a[7:0]};
          default: r = {a[7:0], a[15:8], a[23:16], a[31:24]};
        endcase
      end
      OP_MOVI: r = imm;
      default: r = '0;
    endcase
    run       = cond_true(i.cond, m_flags) && (i.op != OP_NOP);
    e.rd      = i.rd;
    e.data    = r;
    e.written = run && (i.op != OP_CMP);
    e.flags   = m_flags;
    if (run) begin
      e.flags.z = (r == '0);
      e.flags.s = r[`DATA_W-1];
      e.flags.c = c;
      e.flags.v = v;
    end
    if (e.written) m_regs[i.rd] = r;
    m_flags = e.flags;
    exp_q.push_back(e);
    due_q.push_back(cyc + 2);
  endtask

  function automatic insn_t random_insn();
    logic [31:0] r0;
    logic [31:0] r1;
    insn_t       i;
    r0 = $random(seed);
    r1 = $random(seed);
    i.op   = opcode_e'(r0[3:0]);
    i.cond = r0[4] ? CC_AL : cond_e'(r0[8:5]); // half unconditional
    i.rd   = r0[12:9];
    i.ra   = r0[16:13];
    i.rb   = r0[20:17];
    i.imm  = r1[`IMM_W-1:0];
    return i;
  endfunction

  // results are stable around the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (result_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("result_valid seen at %0t ns with no instruction outstanding", $time);
          $display("Verification failed");
          $fatal(1, "unexpected result");
        end else begin
          if (due_q[0] != cyc) begin
            report_mismatch($sformatf("result in cycle %0d, due in cycle %0d", cyc, due_q[0]));
          end
          check_result(result, exp_q[0]);
          check_flags(result.flags, exp_q[0].flags);
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
        report_mismatch($sformatf("result_valid low, result was due in cycle %0d", due_q[0]));
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run went past %0d ns without finishing", WATCHDOG_NS);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed        = 32'h9f70_f4df;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    for (int k = 0; k < `NREGS; k++) begin
      m_regs[k] = '0;
    end
    m_flags = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    while (issued < NUM_INSNS) begin
      roll = $random(seed);
      if (roll % 10 < 8) begin // ~80% issue rate
        instr_valid = 1'b1;
        instr       = random_insn();
        model_issue(instr);
        issued++;
      end else begin
        instr_valid = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    instr_valid = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d issued instructions never produced a result", exp_q.size());
      $display("Verification failed");
      $fatal(1, "missing results");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// ==== src.f ====
+incdir+.
isa_pkg.sv
core_pkg.sv
insn_decode.sv
alu_execute.sv
result_commit.sv
alu_core.sv
tb_alu_core.sv

// ==== Bender.yml ====
package:
  name: alu_core

export_include_dirs:
  - .

sources:
  - files:
      - isa_pkg.sv
      - core_pkg.sv
      - insn_decode.sv
      - alu_execute.sv
      - result_commit.sv
      - alu_core.sv
  - target: simulation
    files:
      - tb_alu_core.sv
